//--- list.f
hw/dcache_bus_pkg.sv
hw/dcache_pkg.sv
hw/store_ram.sv
hw/line_mover.sv
hw/lookup_ctrl.sv
hw/dcache_top.sv
dv/dcache_checker.sv
dv/dcache_tb.sv

//--- run.sh
#!/bin/sh

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module dcache_tb -f list.f -o dcache_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "verilator build failed"
    exit 1
fi

./obj_dir/dcache_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
exit 0

//--- dv/dcache_tb.sv
`timescale 1ns/1ps

module dcache_tb;

    import dcache_bus_pkg::*;

    localparam int WAYS = 4;
    localparam int SETS = 16;
    localparam int WORDS_PER_LINE = 8;
    localparam int INDEX_W = $clog2(SETS);
    localparam int LINE_LSB = 3 + $clog2(WORDS_PER_LINE);
    localparam int TAG_LSB = LINE_LSB + INDEX_W;
    localparam int N_RANDOM = 100;
    localparam int N_DIRECTED = (WAYS + 2) + 2 * (WAYS + 1) + 3;
    localparam int TIMEOUT_NS = (N_DIRECTED + N_RANDOM) * (3 * WORDS_PER_LINE + 8) * 20 * 2;

    logic       clk = 1'b0;
    logic       reset = 1'b0;
    dbus_req_t  dreq = '0;
    dbus_resp_t dresp;
    cbus_req_t  creq;
    cbus_resp_t cresp = '0;
    int         errors;
    int         checks;

    // memory model contents, by word address
    word_t mem [addr_t];
    mlen_t mem_beat = '0;

    always #10 clk = ~clk;

    dcache_top #(
        .WAYS           (WAYS),
        .SETS           (SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) i_dut (
        .clk   (clk),
        .reset (reset),
        .dreq  (dreq),
        .dresp (dresp),
        .creq  (creq),
        .cresp (cresp)
    );

    dcache_checker #(
        .WAYS           (WAYS),
        .SETS           (SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) i_checker (
        .clk    (clk),
        .reset  (reset),
        .dreq   (dreq),
        .dresp  (dresp),
        .creq   (creq),
        .cresp  (cresp),
        .errors (errors),
        .checks (checks)
    );

    function automatic word_t init_word(input addr_t a);
        return {a ^ 32'h5a5a_0f0f, ~a ^ 32'h0123_4567};
    endfunction

    function automatic word_t mem_read(input addr_t a);
        if (mem.exists({a[31:3], 3'b000})) begin
            return mem[{a[31:3], 3'b000}];
        end
        return init_word({a[31:3], 3'b000});
    endfunction

    function automatic addr_t beat_addr(input addr_t base, input mlen_t beat);
        return base + (addr_t'(beat) << 3);
    endfunction

    task automatic store_beat(input addr_t a, input strobe_t strobe, input word_t data);
        word_t w;
        w = mem_read(a);
        for (int b = 0; b < 8; b++) begin
            if (strobe[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        mem[{a[31:3], 3'b000}] = w;
    endtask

    function automatic addr_t cached_addr(input int tag, input int set, input int offset);
        return 32'h8000_0000 | addr_t'(tag << TAG_LSB) | addr_t'(set << LINE_LSB)
             | addr_t'(offset << 3);
    endfunction

    // memory bus slave, ready comes with random gaps
    always @(posedge clk) begin
        if (!reset) begin
            cresp    <= '0;
            mem_beat = '0;
        end else begin
            if (cresp.ready) begin
                if (creq.is_write) begin
                    store_beat(beat_addr(creq.addr, mem_beat), creq.strobe, creq.data);
                end
                mem_beat = cresp.last ? mlen_t'(0) : mem_beat + mlen_t'(1);
            end
            if (creq.valid && !(cresp.ready && cresp.last) && $urandom_range(0, 3) != 0) begin
                cresp.ready <= 1'b1;
                cresp.last  <= mem_beat == creq.len;
                cresp.data  <= mem_read(beat_addr(creq.addr, mem_beat));
            end else begin
                cresp <= '0;
            end
        end
    end

    // request stays up until data_ok
    task automatic access(input addr_t addr, input strobe_t strobe, input word_t data,
                          input msize_t size);
        dreq.valid  <= 1'b1;
        dreq.addr   <= addr;
        dreq.size   <= size;
        dreq.strobe <= strobe;
        dreq.data   <= data;
        do @(posedge clk); while (!dresp.data_ok);
    endtask

    task automatic random_access();
        addr_t   addr;
        strobe_t strobe;
        word_t   data;
        strobe = ($urandom_range(0, 1) == 0) ? strobe_t'(0) : strobe_t'($urandom);
        data   = {$urandom, $urandom};
        if ($urandom_range(0, 7) == 0) begin
            addr = 32'h0000_0100 + addr_t'($urandom_range(0, 15) << 3);
        end else begin
            addr = cached_addr(int'($urandom_range(0, 5)), int'($urandom_range(0, 2)),
                               int'($urandom_range(0, WORDS_PER_LINE - 1)));
        end
        access(addr, strobe, data, MSIZE8);
    endtask

    task automatic finish_run(input logic timed_out);
        $display("checks: %0d, errors: %0d", checks, errors);
        if (!timed_out && errors == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    endtask

    initial begin
        void'($urandom(32'h54f1_c1d1));
        repeat (2) @(posedge clk);
        reset <= 1'b1;
        // idle through the metadata clear, bus must stay quiet
        repeat (SETS + 4) @(posedge clk);
        // clean victims in set 3
        for (int t = 0; t <= WAYS; t++) begin
            access(cached_addr(t, 3, t), '0, '0, MSIZE8);
        end
        access(cached_addr(0, 3, 1), '0, '0, MSIZE8);
        // partial writes in set 5, the last one evicts a dirty line
        for (int t = 0; t <= WAYS; t++) begin
            access(cached_addr(t, 5, 1), 8'h3c, {$urandom, $urandom}, MSIZE8);
        end
        for (int t = 0; t <= WAYS; t++) begin
            access(cached_addr(t, 5, 1), '0, '0, MSIZE8);
        end
        access(32'h0000_1008, 8'h0f, 64'h0123_4567_89ab_cdef, MSIZE4);
        access(32'h0000_1008, '0, '0, MSIZE4);
        access(32'h0000_2010, '0, '0, MSIZE8);
        for (int i = 0; i < N_RANDOM; i++) begin
            random_access();
        end
        dreq.valid <= 1'b0;
        repeat (4) @(posedge clk);
        finish_run(1'b0);
    end

    initial begin
        #(TIMEOUT_NS);
        $display("timeout: no data_ok after %0d ns", TIMEOUT_NS);
        finish_run(1'b1);
    end

endmodule

//--- dv/dcache_checker.sv
`timescale 1ns/1ps

module dcache_checker #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_bus_pkg::dbus_req_t  dreq,
    input  dcache_bus_pkg::dbus_resp_t dresp,
    input  dcache_bus_pkg::cbus_req_t  creq,
    input  dcache_bus_pkg::cbus_resp_t cresp,
    output int                         errors,
    output int                         checks
);

    import dcache_bus_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int LINE_LSB = 3 + $clog2(WORDS_PER_LINE);
    localparam int TAG_LSB = LINE_LSB + INDEX_W;

    int error_count = 0;
    int check_count = 0;

    // word-address map of every write seen so far
    word_t shadow [addr_t];

    logic  model_valid [SETS][WAYS];
    logic  model_dirty [SETS][WAYS];
    addr_t model_tag [SETS][WAYS];
    int    model_age [SETS][WAYS];

    logic      busy;
    dbus_req_t req;
    int        req_set;
    int        req_way;
    logic      req_hit;
    logic      want_evict;
    addr_t     evict_line;
    int        cycles;
    int        fills;
    int        evicts;
    int        singles;

    logic      in_txn;
    cbus_req_t txn;
    int        beats;

    assign errors = error_count;
    assign checks = check_count;

    function automatic word_t init_word(input addr_t a);
        return {a ^ 32'h5a5a_0f0f, ~a ^ 32'h0123_4567};
    endfunction

    // reference model of a load
    function automatic word_t expected_read(input addr_t a);
        addr_t w;
        w = {a[31:3], 3'b000};
        if (shadow.exists(w)) begin
            return shadow[w];
        end
        return init_word(w);
    endfunction

    task automatic merge_write(input addr_t a, input strobe_t strobe, input word_t data);
        word_t w;
        w = expected_read(a);
        for (int b = 0; b < 8; b++) begin
            if (strobe[b]) begin
                w[8*b +: 8] = data[8*b +: 8];
            end
        end
        shadow[{a[31:3], 3'b000}] = w;
    endtask

    task automatic report(input string msg);
        error_count++;
        $display("error at %0t: %s", $time, msg);
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] want);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("FAILED %s at %0t: got %h, expected %h", name, $time, got, want);
        end
    endtask

    task automatic check_total(input string what, input int got, input int want);
        check_count++;
        if (got != want) begin
            report($sformatf("expected %0d %s for %h, saw %0d", want, what, req.addr, got));
        end
    endtask

    task automatic reset_model();
        busy   = 1'b0;
        in_txn = 1'b0;
        for (int s = 0; s < SETS; s++) begin
            for (int w = 0; w < WAYS; w++) begin
                model_valid[s][w] = 1'b0;
                model_dirty[s][w] = 1'b0;
                model_tag[s][w]   = '0;
                model_age[s][w]   = w;
            end
        end
    endtask

    // hit or miss and the victim on a miss
    task automatic start_request();
        addr_t tg;
        req        = dreq;
        busy       = 1'b1;
        cycles     = 0;
        fills      = 0;
        evicts     = 0;
        singles    = 0;
        want_evict = 1'b0;
        req_hit    = 1'b0;
        req_way    = -1;
        req_set    = int'(dreq.addr[LINE_LSB +: INDEX_W]);
        tg         = dreq.addr >> TAG_LSB;
        if (dreq.addr[31]) begin
            for (int w = 0; w < WAYS; w++) begin
                if (model_valid[req_set][w] && model_tag[req_set][w] == tg) begin
                    req_hit = 1'b1;
                    req_way = w;
                end
            end
            if (!req_hit) begin
                for (int w = WAYS - 1; w >= 0; w--) begin
                    if (!model_valid[req_set][w]) begin
                        req_way = w;
                    end
                end
                if (req_way < 0) begin
                    for (int w = 0; w < WAYS; w++) begin
                        if (model_age[req_set][w] == WAYS - 1) begin
                            req_way = w;
                        end
                    end
                end
                want_evict = model_dirty[req_set][req_way];
                evict_line = (model_tag[req_set][req_way] << TAG_LSB)
                           | addr_t'(req_set << LINE_LSB);
            end
        end
    endtask

    task automatic finish_request();
        int age;
        if (req.strobe == '0) begin
            check_value("dresp.data", dresp.data, expected_read(req.addr));
        end else begin
            merge_write(req.addr, req.strobe, req.data);
        end
        if (!req.addr[31]) begin
            check_total("single-beat transactions", singles, 1);
        end else begin
            if (req_hit) begin
                check_total("cycles from lookup to data_ok", cycles, 1);
            end
            check_total("fill bursts", fills, req_hit ? 0 : 1);
            check_total("write bursts", evicts, want_evict ? 1 : 0);
            if (!req_hit) begin
                model_dirty[req_set][req_way] = 1'b0;
            end
            if (req.strobe != '0) begin
                model_dirty[req_set][req_way] = 1'b1;
            end
            model_valid[req_set][req_way] = 1'b1;
            model_tag[req_set][req_way]   = req.addr >> TAG_LSB;
            age = model_age[req_set][req_way];
            for (int w = 0; w < WAYS; w++) begin
                if (model_age[req_set][w] < age) begin
                    model_age[req_set][w]++;
                end
            end
            model_age[req_set][req_way] = 0;
        end
        busy = 1'b0;
    endtask

    task automatic start_txn();
        addr_t line;
        in_txn = 1'b1;
        txn    = creq;
        beats  = 0;
        line   = {req.addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
        if (!busy) begin
            report("memory bus transaction without a pending request");
        end else if (!req.addr[31]) begin
            singles++;
            check_value("creq.addr", 64'(creq.addr), 64'(req.addr));
            check_value("creq.size", 64'(creq.size), 64'(req.size));
            check_value("creq.strobe", 64'(creq.strobe), 64'(req.strobe));
            check_value("creq.is_write", 64'(creq.is_write), 64'(|req.strobe));
            check_value("creq.len", 64'(creq.len), 64'd0);
            if (|req.strobe) begin
                check_value("creq.data", creq.data, req.data);
            end
        end else if (creq.is_write) begin
            evicts++;
            if (!want_evict) begin
                report($sformatf("write burst to %h without a dirty victim", creq.addr));
            end else begin
                check_value("creq.addr", 64'(creq.addr), 64'(evict_line));
            end
            check_value("creq.len", 64'(creq.len), 64'(WORDS_PER_LINE - 1));
        end else begin
            fills++;
            check_value("creq.addr", 64'(creq.addr), 64'(line));
            check_value("creq.len", 64'(creq.len), 64'(WORDS_PER_LINE - 1));
        end
    endtask

    task automatic track_beat();
        if (!creq.valid) begin
            report("creq.valid dropped before the last beat");
            in_txn = 1'b0;
        end else if (cresp.ready) begin
            // written-back line must match the shadow copy
            if (txn.is_write && txn.addr[31]) begin
                check_value("creq.data", creq.data,
                            expected_read(txn.addr + (addr_t'(beats) << 3)));
            end
            beats++;
            if (cresp.last) begin
                in_txn = 1'b0;
                check_total("beats in the burst", beats, req.addr[31] ? WORDS_PER_LINE : 1);
            end
        end
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            reset_model();
        end else begin
            if (busy) begin
                cycles++;
            end
            if (dresp.data_ok && !busy) begin
                report("data_ok without a pending request");
            end
            if (creq.valid && !in_txn) begin
                start_txn();
            end
            if (in_txn) begin
                track_beat();
            end
            if (busy && dresp.data_ok) begin
                finish_request();
            end else if (!busy && dreq.valid) begin
                start_request();
            end
        end
    end

endmodule

//--- hw/dcache_top.sv
`timescale 1ns/1ps

module dcache_top #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    parameter int WORDS_PER_LINE = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_bus_pkg::dbus_req_t  dreq,
    output dcache_bus_pkg::dbus_resp_t dresp,
    output dcache_bus_pkg::cbus_req_t  creq,
    input  dcache_bus_pkg::cbus_resp_t cresp
);

    import dcache_bus_pkg::*;
    import dcache_pkg::*;

    localparam int INDEX_W = $clog2(SETS);
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE);
    localparam int TAG_W = 29 - INDEX_W - OFFSET_W;
    localparam int DATA_DEPTH = SETS * WAYS * WORDS_PER_LINE;
    localparam int DATA_AW = $clog2(DATA_DEPTH);

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } meta_t;

    typedef meta_t [WAYS-1:0] meta_row_t;

    typedef struct packed {
        logic               en;
        logic [WAYS-1:0]    strobe;
        logic [INDEX_W-1:0] addr;
        meta_row_t          wdata;
    } meta_req_t;

    meta_row_t   meta_rdata;
    meta_req_t   meta_req;
    store_req_t  data_req;
    word_t       data_rdata;
    line_cmd_t   cmd;
    mover_resp_t mover_resp;
    store_req_t  mover_store_req;

    lookup_ctrl #(
        .WAYS           (WAYS),
        .SETS           (SETS),
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) i_lookup (
        .clk             (clk),
        .reset           (reset),
        .dreq            (dreq),
        .dresp           (dresp),
        .meta_rdata      (meta_rdata),
        .meta_req        (meta_req),
        .data_rdata      (data_rdata),
        .data_req        (data_req),
        .cmd             (cmd),
        .mover_resp      (mover_resp),
        .mover_store_req (mover_store_req)
    );

    line_mover #(
        .WORDS_PER_LINE (WORDS_PER_LINE)
    ) i_mover (
        .clk         (clk),
        .reset       (reset),
        .cmd         (cmd),
        .resp        (mover_resp),
        .store_req   (mover_store_req),
        .store_rdata (data_rdata),
        .creq        (creq),
        .cresp       (cresp)
    );

    // one word per entry, byte lanes
    store_ram #(
        .payload_t    (word_t),
        .LANES        ($bits(strobe_t)),
        .DEPTH        (DATA_DEPTH),
        .READ_LATENCY (1)
    ) data_store (
        .clk    (clk),
        .en     (data_req.en),
        .strobe (data_req.strobe),
        .addr   (data_req.addr[DATA_AW-1:0]),
        .wdata  (data_req.wdata),
        .rdata  (data_rdata)
    );

    // one row per set, one lane per way
    store_ram #(
        .payload_t    (meta_row_t),
        .LANES        (WAYS),
        .DEPTH        (SETS),
        .READ_LATENCY (0)
    ) meta_store (
        .clk    (clk),
        .en     (meta_req.en),
        .strobe (meta_req.strobe),
        .addr   (meta_req.addr),
        .wdata  (meta_req.wdata),
        .rdata  (meta_rdata)
    );

endmodule

//--- hw/lookup_ctrl.sv
`timescale 1ns/1ps

module lookup_ctrl #(
    parameter int WAYS = 4,
    parameter int SETS = 16,
    parameter int WORDS_PER_LINE = 8,
    localparam int INDEX_W = $clog2(SETS),
    localparam int OFFSET_W = $clog2(WORDS_PER_LINE),
    localparam int TAG_W = 29 - INDEX_W - OFFSET_W,
    localparam int ROW_W = WAYS * (TAG_W + 2)
) (
    input  logic                        clk,
    input  logic                        reset,
    input  dcache_bus_pkg::dbus_req_t   dreq,
    output dcache_bus_pkg::dbus_resp_t  dresp,
    input  logic [ROW_W-1:0]            meta_rdata,
    output logic [ROW_W+WAYS+INDEX_W:0] meta_req,
    input  dcache_bus_pkg::word_t       data_rdata,
    output dcache_pkg::store_req_t      data_req,
    output dcache_pkg::line_cmd_t       cmd,
    input  dcache_pkg::mover_resp_t     mover_resp,
    input  dcache_pkg::store_req_t      mover_store_req
);

    import dcache_bus_pkg::*;
    import dcache_pkg::*;

    localparam int WAY_W = (WAYS > 1) ? $clog2(WAYS) : 1;
    localparam int LINE_LSB = 3 + OFFSET_W;

    typedef struct packed {
        logic             valid;
        logic             dirty;
        logic [TAG_W-1:0] tag;
    } meta_t;

    typedef meta_t [WAYS-1:0] meta_row_t;

    typedef struct packed {
        logic               en;
        logic [WAYS-1:0]    strobe;
        logic [INDEX_W-1:0] addr;
        meta_row_t          wdata;
    } meta_req_t;

    ctrl_state_t         state;
    logic [INDEX_W-1:0]  clear_idx;
    logic [WAY_W-1:0]    ages [SETS][WAYS];
    logic [WAY_W-1:0]    hit_way_q;
    logic [WAY_W-1:0]    fill_way;

    meta_row_t           rows;
    meta_req_t           mreq;
    meta_t               lane;
    store_req_t          hit_req;

    logic [OFFSET_W-1:0] offset;
    logic [INDEX_W-1:0]  index;
    logic [TAG_W-1:0]    tag;
    logic                cached;
    logic                lookup;
    logic                hit;
    logic                has_empty;
    logic [WAY_W-1:0]    hit_way;
    logic [WAY_W-1:0]    empty_way;
    logic [WAY_W-1:0]    lru_way;
    logic [WAY_W-1:0]    victim;
    addr_t               line_addr;
    addr_t               victim_addr;

    function automatic store_addr_t line_base(input logic [INDEX_W-1:0] set,
                                              input logic [WAY_W-1:0] way);
        return store_addr_t'((int'(set) * WAYS + int'(way)) * WORDS_PER_LINE);
    endfunction

    function automatic line_cmd_t make_cmd(input cmd_kind_t kind, input addr_t addr,
                                           input store_addr_t base);
        line_cmd_t c;
        c.start  = 1'b1;
        c.kind   = kind;
        c.addr   = addr;
        c.base   = base;
        c.size   = dreq.size;
        c.strobe = dreq.strobe;
        c.data   = dreq.data;
        return c;
    endfunction

    assign rows     = meta_rdata;
    assign meta_req = mreq;

    assign offset = dreq.addr[3 +: OFFSET_W];
    assign index  = dreq.addr[LINE_LSB +: INDEX_W];
    assign tag    = dreq.addr[31 -: TAG_W];
    assign cached = dreq.addr[31];
    assign lookup = state == S_IDLE && dreq.valid && cached;

    assign line_addr   = {dreq.addr[31:LINE_LSB], {LINE_LSB{1'b0}}};
    assign victim_addr = {rows[victim].tag, index, {LINE_LSB{1'b0}}};

    always_comb begin
        hit       = 1'b0;
        hit_way   = '0;
        has_empty = 1'b0;
        empty_way = '0;
        lru_way   = '0;
        // downward scan leaves the lowest empty way
        for (int w = WAYS - 1; w >= 0; w--) begin
            if (!rows[w].valid) begin
                has_empty = 1'b1;
                empty_way = WAY_W'(w);
            end
        end
        for (int w = 0; w < WAYS; w++) begin
            if (rows[w].valid && rows[w].tag == tag) begin
                hit     = 1'b1;
                hit_way = WAY_W'(w);
            end
            if (ages[index][w] == WAY_W'(WAYS - 1)) begin
                lru_way = WAY_W'(w);
            end
        end
        victim = has_empty ? empty_way : lru_way;
    end

    always_comb begin
        hit_req.en     = lookup && hit;
        hit_req.strobe = dreq.strobe;
        hit_req.addr   = line_base(index, hit_way) + store_addr_t'(offset);
        hit_req.wdata  = dreq.data;
    end

    assign data_req = (state == S_EVICT || state == S_FILL) ? mover_store_req : hit_req;

    assign lane.valid = state != S_CLEAR;
    assign lane.dirty = state == S_RESPOND;
    assign lane.tag   = (state == S_CLEAR) ? '0 : tag;

    // lane strobes pick the way, every lane carries the same value
    always_comb begin
        mreq.en     = 1'b0;
        mreq.strobe = '0;
        mreq.addr   = (state == S_CLEAR) ? clear_idx : index;
        for (int w = 0; w < WAYS; w++) begin
            mreq.wdata[w] = lane;
        end
        case (state)
            S_CLEAR: begin
                mreq.en     = 1'b1;
                mreq.strobe = '1;
            end
            S_RESPOND: begin
                if (|dreq.strobe) begin
                    mreq.en                = 1'b1;
                    mreq.strobe[hit_way_q] = 1'b1;
                end
            end
            S_FILL: begin
                if (mover_resp.done) begin
                    mreq.en               = 1'b1;
                    mreq.strobe[fill_way] = 1'b1;
                end
            end
            default: ;
        endcase
    end

    assign dresp.data_ok = state == S_RESPOND || (state == S_UNCACHED && mover_resp.done);
    assign dresp.data    = (state == S_UNCACHED) ? mover_resp.data : data_rdata;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= S_CLEAR;
            clear_idx <= '0;
            cmd.start <= 1'b0;
        end else begin
            cmd.start <= 1'b0;
            case (state)
                S_CLEAR: begin
                    // ages start as a permutation of way numbers
                    for (int w = 0; w < WAYS; w++) begin
                        ages[clear_idx][w] <= WAY_W'(w);
                    end
                    clear_idx <= clear_idx + 1'b1;
                    if (clear_idx == INDEX_W'(SETS - 1)) begin
                        state <= S_IDLE;
                    end
                end
                S_IDLE: begin
                    if (dreq.valid && !cached) begin
                        cmd   <= make_cmd(CMD_SINGLE, dreq.addr, '0);
                        state <= S_UNCACHED;
                    end else if (lookup && hit) begin
                        hit_way_q <= hit_way;
                        for (int w = 0; w < WAYS; w++) begin
                            if (ages[index][w] < ages[index][hit_way]) begin
                                ages[index][w] <= ages[index][w] + 1'b1;
                            end
                        end
                        ages[index][hit_way] <= '0;
                        state <= S_RESPOND;
                    end else if (lookup) begin
                        fill_way <= victim;
                        if (rows[victim].valid && rows[victim].dirty) begin
                            cmd   <= make_cmd(CMD_EVICT, victim_addr, line_base(index, victim));
                            state <= S_EVICT;
                        end else begin
                            cmd   <= make_cmd(CMD_FILL, line_addr, line_base(index, victim));
                            state <= S_FILL;
                        end
                    end
                end
                S_RESPOND: state <= S_IDLE;
                S_EVICT: begin
                    if (mover_resp.done) begin
                        cmd   <= make_cmd(CMD_FILL, line_addr, line_base(index, fill_way));
                        state <= S_FILL;
                    end
                end
                // back to IDLE for the re-lookup
                S_FILL: begin
                    if (mover_resp.done) begin
                        state <= S_IDLE;
                    end
                end
                S_UNCACHED: begin
                    if (mover_resp.done) begin
                        state <= S_IDLE;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

endmodule

//--- hw/line_mover.sv
`timescale 1ns/1ps

module line_mover #(
    parameter int WORDS_PER_LINE = 8
) (
    input  logic                       clk,
    input  logic                       reset,
    input  dcache_pkg::line_cmd_t      cmd,
    output dcache_pkg::mover_resp_t    resp,
    output dcache_pkg::store_req_t     store_req,
    input  dcache_bus_pkg::word_t      store_rdata,
    output dcache_bus_pkg::cbus_req_t  creq,
    input  dcache_bus_pkg::cbus_resp_t cresp
);

    import dcache_bus_pkg::*;
    import dcache_pkg::*;

    localparam int OFF_W = $clog2(WORDS_PER_LINE);
    localparam int CNT_W = OFF_W + 1;

    typedef enum logic [1:0] {
        MV_IDLE,
        MV_LOAD,
        MV_BUS
    } mv_state_t;

    mv_state_t  state;
    line_cmd_t  cur;
    logic [CNT_W-1:0] load_cnt;
    logic [OFF_W-1:0] beat;
    word_t      line_buf [WORDS_PER_LINE];
    logic       is_evict;
    logic       is_fill;
    logic       is_single;

    assign is_evict  = cur.kind == CMD_EVICT;
    assign is_fill   = cur.kind == CMD_FILL;
    assign is_single = cur.kind == CMD_SINGLE;

    always_ff @(posedge clk) begin
        if (!reset) begin
            state     <= MV_IDLE;
            resp.done <= 1'b0;
        end else begin
            resp.done <= 1'b0;
            case (state)
                MV_IDLE: begin
                    if (cmd.start) begin
                        cur      <= cmd;
                        load_cnt <= '0;
                        beat     <= '0;
                        state    <= (cmd.kind == CMD_EVICT) ? MV_LOAD : MV_BUS;
                    end
                end
                MV_LOAD: begin
                    load_cnt <= load_cnt + 1'b1;
                    if (load_cnt == CNT_W'(WORDS_PER_LINE)) begin
                        state <= MV_BUS;
                    end
                end
                MV_BUS: begin
                    if (cresp.ready) begin
                        beat <= beat + 1'b1;
                        if (cresp.last) begin
                            state     <= MV_IDLE;
                            resp.done <= 1'b1;
                            resp.data <= cresp.data;
                        end
                    end
                end
                default: state <= MV_IDLE;
            endcase
        end
    end

    // store data arrives one cycle after the read
    always_ff @(posedge clk) begin
        if (state == MV_LOAD && load_cnt != '0) begin
            line_buf[OFF_W'(load_cnt - 1'b1)] <= store_rdata;
        end
    end

    always_comb begin
        store_req.en     = 1'b0;
        store_req.strobe = '1;
        store_req.addr   = cur.base + store_addr_t'(beat);
        store_req.wdata  = cresp.data;
        if (state == MV_LOAD) begin
            store_req.en     = load_cnt < CNT_W'(WORDS_PER_LINE);
            store_req.strobe = '0;
            store_req.addr   = cur.base + store_addr_t'(load_cnt);
        end else if (state == MV_BUS && is_fill) begin
            store_req.en = cresp.ready;
        end
    end

    assign creq.valid    = state == MV_BUS;
    assign creq.is_write = is_evict || (is_single && |cur.strobe);
    assign creq.addr     = cur.addr;
    assign creq.size     = is_single ? cur.size : MSIZE8;
    assign creq.strobe   = is_single ? cur.strobe : {$bits(strobe_t){is_evict}};
    assign creq.data     = is_single ? cur.data : line_buf[beat];
    assign creq.len      = is_single ? mlen_t'(0) : mlen_t'(WORDS_PER_LINE - 1);

endmodule

//--- hw/store_ram.sv
`timescale 1ns/1ps

module store_ram #(
    parameter type payload_t = logic [63:0],
    parameter int LANES = 8,
    parameter int DEPTH = 256,
    parameter int READ_LATENCY = 1
) (
    input  logic                     clk,
    input  logic                     en,
    input  logic [LANES-1:0]         strobe,
    input  logic [$clog2(DEPTH)-1:0] addr,
    input  payload_t                 wdata,
    output payload_t                 rdata
);

    localparam int LANE_BITS = $bits(payload_t) / LANES;

    typedef logic [LANES-1:0][LANE_BITS-1:0] lanes_t;

    lanes_t mem [DEPTH];
    lanes_t wlanes;

    assign wlanes = lanes_t'(wdata);

    always_ff @(posedge clk) begin
        if (en) begin
            for (int i = 0; i < LANES; i++) begin
                if (strobe[i]) begin
                    mem[addr][i] <= wlanes[i];
                end
            end
        end
    end

    // metadata is read in the lookup cycle
    if (READ_LATENCY == 0) begin : g_async_read
        assign rdata = payload_t'(mem[addr]);
    end else begin : g_sync_read
        always_ff @(posedge clk) begin
            if (en) begin
                rdata <= payload_t'(mem[addr]);
            end
        end
    end

endmodule

//--- hw/dcache_pkg.sv
package dcache_pkg;

    typedef enum logic [2:0] {
        S_CLEAR,
        S_IDLE,
        S_RESPOND,
        S_EVICT,
        S_FILL,
        S_UNCACHED
    } ctrl_state_t;

    // word index into the data store
    typedef logic [15:0] store_addr_t;

    typedef enum logic [1:0] {
        CMD_FILL,
        CMD_EVICT,
        CMD_SINGLE
    } cmd_kind_t;

    typedef struct packed {
        logic                     start;
        cmd_kind_t                kind;
        dcache_bus_pkg::addr_t    addr;
        store_addr_t              base;
        dcache_bus_pkg::msize_t   size;
        dcache_bus_pkg::strobe_t  strobe;
        dcache_bus_pkg::word_t    data;
    } line_cmd_t;

    typedef struct packed {
        logic                    en;
        dcache_bus_pkg::strobe_t strobe;
        store_addr_t             addr;
        dcache_bus_pkg::word_t   wdata;
    } store_req_t;

    typedef struct packed {
        logic                  done;
        dcache_bus_pkg::word_t data;
    } mover_resp_t;

endpackage

//--- hw/dcache_bus_pkg.sv
package dcache_bus_pkg;

    typedef logic [31:0] addr_t;
    typedef logic [63:0] word_t;
    typedef logic [7:0]  strobe_t;
    typedef logic [2:0]  msize_t;
    // beats minus one
    typedef logic [7:0]  mlen_t;

    localparam msize_t MSIZE1 = 3'b000;
    localparam msize_t MSIZE2 = 3'b001;
    localparam msize_t MSIZE4 = 3'b010;
    localparam msize_t MSIZE8 = 3'b011;

    typedef struct packed {
        logic    valid;
        addr_t   addr;
        msize_t  size;
        strobe_t strobe;
        word_t   data;
    } dbus_req_t;

    typedef struct packed {
        logic  data_ok;
        word_t data;
    } dbus_resp_t;

    typedef struct packed {
        logic    valid;
        logic    is_write;
        addr_t   addr;
        msize_t  size;
        strobe_t strobe;
        word_t   data;
        mlen_t   len;
    } cbus_req_t;

    typedef struct packed {
        logic  ready;
        logic  last;
        word_t data;
    } cbus_resp_t;

endpackage
